// ==== hw/spi_ctrl_settings.svh ====
`ifndef SPI_CTRL_SETTINGS_SVH
`define SPI_CTRL_SETTINGS_SVH

`define SPI_NCS          4
`define SPI_ADDR_W       8
`define SPI_DATA_W       32
`define SPI_TXBUF_WORDS  32
`define SPI_RXQ_DEPTH    32

// register map, byte addresses
`define SPI_ADDR_SPMODE  8'h00
`define SPI_ADDR_SPIE    8'h04
`define SPI_ADDR_SPIM    8'h08
`define SPI_ADDR_SPCOM   8'h0C
`define SPI_ADDR_SPITF   8'h10
`define SPI_ADDR_SPIRF   8'h14
`define SPI_ADDR_CSMODE0 8'h20

`define SPI_SPMODE_EN    31
`define SPI_SPIE_DON     0

// cs mode fields
`define SPI_CSM_CPOL     29
`define SPI_CSM_CPHA     28
`define SPI_CSM_DIV16    27
`define SPI_CSM_REV      26
`define SPI_CSM_PM_LO    20
`define SPI_CSM_PM_HI    23
`define SPI_CSM_LEN_LO   16
`define SPI_CSM_LEN_HI   19 // char length minus 1
`define SPI_CSM_BEF_LO   8
`define SPI_CSM_BEF_HI   11
`define SPI_CSM_AFT_LO   4
`define SPI_CSM_AFT_HI   7

`define SPI_COM_CS_LO    30
`define SPI_COM_CS_HI    31
`define SPI_COM_LEN_LO   0
`define SPI_COM_LEN_HI   15

`endif

// ==== hw/spi_reg_pkg.sv ====
`default_nettype none

package spi_reg_pkg;

    // one tx buffer word, two 16-bit or four 8-bit chars
    typedef union packed {
        logic [1:0][15:0] c16;
        logic [3:0][7:0]  c8;
    } tx_word_u;

endpackage

`default_nettype wire

// ==== hw/spi_link_pkg.sv ====
`default_nettype none

package spi_link_pkg;

    localparam logic [1:0] FS_IDLE   = 2'd0;
    localparam logic [1:0] FS_BEFORE = 2'd1;
    localparam logic [1:0] FS_SHIFT  = 2'd2;
    localparam logic [1:0] FS_AFTER  = 2'd3;

    // chars packed in one tx word for a given length field
    function automatic logic [2:0] chars_per_word(input logic [3:0] len);
        return (len > 4'd7) ? 3'd2 : 3'd4;
    endfunction

endpackage

`default_nettype wire

// ==== hw/spi_baud_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_baud_gen (
    input  wire        S_SYSCLK,
    input  wire        S_RESETN,
    input  wire        i_run,
    input  wire        i_cpol,
    input  wire  [7:0] i_divider, // half period minus 1
    output logic       o_sck,
    output logic       o_lead,
    output logic       o_trail
);

    logic [7:0] cnt;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt     <= 8'd0;
            o_sck   <= 1'b0;
            o_lead  <= 1'b0;
            o_trail <= 1'b0;
        end else begin
            o_lead  <= 1'b0;
            o_trail <= 1'b0;
            if (!i_run) begin
                cnt   <= 8'd0;
                o_sck <= i_cpol; // park at idle level
            end else if (cnt == i_divider) begin
                cnt     <= 8'd0;
                o_sck   <= ~o_sck;
                o_lead  <= (o_sck == i_cpol);
                o_trail <= (o_sck != i_cpol);
            end else begin
                cnt <= cnt + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_frame_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "spi_ctrl_settings.svh"

module spi_frame_engine (
    input  wire                                       S_SYSCLK,
    input  wire                                       S_RESETN,
    input  wire                                       i_enable,
    input  wire                                       i_start,
    input  wire  [`SPI_COM_CS_HI-`SPI_COM_CS_LO:0]    i_cs_idx,
    input  wire  [`SPI_COM_LEN_HI-`SPI_COM_LEN_LO:0]  i_tranlen,
    input  wire  [`SPI_DATA_W-1:0]                    i_csmode,
    input  wire  spi_reg_pkg::tx_word_u               i_tx_word,
    input  wire                                       i_lead,
    input  wire                                       i_trail,
    input  wire                                       i_sck,
    input  wire                                       i_spi_miso,
    output logic                                      o_run,
    output logic [7:0]                                o_divider,
    output logic [$clog2(`SPI_TXBUF_WORDS)-1:0]       o_tx_idx,
    output logic                                      o_spi_sck,
    output logic                                      o_spi_mosi,
    output logic [`SPI_NCS-1:0]                       o_spi_sel,
    output logic                                      o_rx_valid,
    output logic [15:0]                               o_rx_char,
    output logic                                      o_frame_done,
    output logic                                      o_busy
);

    import spi_link_pkg::*;

    localparam int TXW = $clog2(`SPI_TXBUF_WORDS);

    logic [1:0]                 state;
    logic                       gap;     // one idle cycle restarts the baud phase
    logic [`SPI_DATA_W-1:0]     mode_q;
    logic [15:0]                tranlen_q;
    logic [3:0]                 cnt_d;
    logic [16:0]                ld_cnt;  // index of next char to load
    logic [3:0]                 bitn;
    logic [15:0]                sh;
    logic [15:0]                rx_sh;
    logic [15:0]                rx_upd;
    logic                       mosi_q;
    logic [3:0]                 len;
    logic                       cpha;
    logic                       rev;
    logic [2:0]                 cpw;
    logic [3:0]                 pos;
    logic [15:0]                char_in;
    logic [7:0]                 pm1;
    logic                       next_out;
    logic                       last;
    logic                       load;
    logic                       sample;
    logic                       shift_e;
    logic                       char_end;

    assign len  = mode_q[`SPI_CSM_LEN_HI:`SPI_CSM_LEN_LO];
    assign cpha = mode_q[`SPI_CSM_CPHA];
    assign rev  = mode_q[`SPI_CSM_REV];
    assign cpw  = chars_per_word(len);

    assign o_tx_idx = (cpw == 3'd2) ? ld_cnt[TXW:1] : ld_cnt[TXW+1:2];
    assign char_in  = (cpw == 3'd2) ? i_tx_word.c16[ld_cnt[0]]
                                    : {8'h00, i_tx_word.c8[ld_cnt[1:0]]};

    assign last     = (ld_cnt == {1'b0, tranlen_q} + 17'd1);
    assign char_end = (state == FS_SHIFT) && i_trail && (bitn == len);
    assign load     = ((state == FS_BEFORE) && (cnt_d == 4'd0)) || (char_end && !last);
    assign sample   = (state == FS_SHIFT) && (cpha ? i_trail : i_lead);
    assign shift_e  = (state == FS_SHIFT) && (cpha ? i_lead : i_trail);

    assign pos      = rev ? (len - bitn) : bitn;
    assign next_out = rev ? sh[len] : sh[0];

    always_comb begin
        rx_upd      = rx_sh;
        rx_upd[pos] = i_spi_miso;
    end

    assign pm1       = {4'h0, mode_q[`SPI_CSM_PM_HI:`SPI_CSM_PM_LO]} + 8'd1;
    assign o_divider = mode_q[`SPI_CSM_DIV16] ? ((pm1 << 4) - 8'd1) : ((pm1 << 1) - 8'd1);
    assign o_run     = (state != FS_IDLE) && !gap;
    assign o_busy    = (state != FS_IDLE);
    assign o_spi_sck = (state == FS_SHIFT && !gap) ? i_sck : i_csmode[`SPI_CSM_CPOL];
    assign o_spi_mosi = cpha ? mosi_q : next_out;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state        <= FS_IDLE;
            gap          <= 1'b0;
            mode_q       <= '0;
            tranlen_q    <= 16'd0;
            cnt_d        <= 4'd0;
            ld_cnt       <= 17'd0;
            bitn         <= 4'd0;
            o_spi_sel    <= '1;
            o_rx_valid   <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            gap          <= 1'b0;
            o_rx_valid   <= 1'b0;
            o_frame_done <= 1'b0;
            if (!i_enable && state != FS_IDLE) begin
                state     <= FS_IDLE; // abort on disable
                o_spi_sel <= '1;
            end else begin
                case (state)
                    FS_IDLE: if (i_start && i_enable) begin
                        mode_q    <= i_csmode;
                        tranlen_q <= i_tranlen;
                        cnt_d     <= i_csmode[`SPI_CSM_BEF_HI:`SPI_CSM_BEF_LO];
                        ld_cnt    <= 17'd0;
                        bitn      <= 4'd0;
                        o_spi_sel <= ~(`SPI_NCS'(1) << i_cs_idx);
                        gap       <= 1'b1;
                        state     <= FS_BEFORE;
                    end
                    FS_BEFORE: begin
                        if (cnt_d == 4'd0) begin
                            gap   <= 1'b1;
                            state <= FS_SHIFT;
                        end else if (i_lead || i_trail) begin
                            cnt_d <= cnt_d - 4'd1;
                        end
                    end
                    FS_SHIFT: if (i_trail) begin
                        if (bitn == len) begin
                            bitn       <= 4'd0;
                            o_rx_valid <= 1'b1;
                            if (last) begin
                                cnt_d <= mode_q[`SPI_CSM_AFT_HI:`SPI_CSM_AFT_LO];
                                gap   <= 1'b1;
                                state <= FS_AFTER;
                            end
                        end else begin
                            bitn <= bitn + 4'd1;
                        end
                    end
                    default: begin
                        if (cnt_d == 4'd0) begin
                            o_spi_sel    <= '1;
                            o_frame_done <= 1'b1;
                            state        <= FS_IDLE;
                        end else if (i_lead || i_trail) begin
                            cnt_d <= cnt_d - 4'd1;
                        end
                    end
                endcase
                if (load) begin
                    ld_cnt <= ld_cnt + 17'd1;
                end
            end
        end
    end

    // shift path
    always_ff @(posedge S_SYSCLK) begin
        if (sample) begin
            rx_sh <= rx_upd;
        end
        if (char_end) begin
            o_rx_char <= cpha ? rx_upd : rx_sh;
        end
        if (load) begin
            sh    <= char_in;
            rx_sh <= 16'h0000;
        end else if (shift_e) begin
            sh <= rev ? (sh << 1) : (sh >> 1);
        end
        if (shift_e && cpha) begin
            mosi_q <= next_out;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "spi_ctrl_settings.svh"

module spi_axil_regs (
    input  wire                                       S_SYSCLK,
    input  wire                                       S_RESETN,
    input  wire  [`SPI_ADDR_W-1:0]                    i_awaddr,
    input  wire                                       i_awvalid,
    output logic                                      o_awready,
    input  wire  [`SPI_DATA_W-1:0]                    i_wdata,
    input  wire  [3:0]                                i_wstrb,
    input  wire                                       i_wvalid,
    output logic                                      o_wready,
    output logic [1:0]                                o_bresp,
    output logic                                      o_bvalid,
    input  wire                                       i_bready,
    input  wire  [`SPI_ADDR_W-1:0]                    i_araddr,
    input  wire                                       i_arvalid,
    output logic                                      o_arready,
    output logic [`SPI_DATA_W-1:0]                    o_rdata,
    output logic [1:0]                                o_rresp,
    output logic                                      o_rvalid,
    input  wire                                       i_rready,
    input  wire                                       i_rx_valid,
    input  wire  [15:0]                               i_rx_char,
    input  wire                                       i_frame_done,
    input  wire                                       i_busy,
    input  wire  [$clog2(`SPI_TXBUF_WORDS)-1:0]       i_tx_idx,
    output logic                                      o_enable,
    output logic                                      o_start,
    output logic [`SPI_COM_CS_HI-`SPI_COM_CS_LO:0]    o_cs_idx,
    output logic [`SPI_COM_LEN_HI-`SPI_COM_LEN_LO:0]  o_tranlen,
    output logic [`SPI_DATA_W-1:0]                    o_csmode,
    output spi_reg_pkg::tx_word_u                     o_tx_word,
    output logic                                      o_interrupt
);

    import spi_reg_pkg::*;
    import spi_link_pkg::*;

    localparam int TXW = $clog2(`SPI_TXBUF_WORDS);
    localparam int RXW = $clog2(`SPI_RXQ_DEPTH);

    logic [`SPI_DATA_W-1:0] spmode;
    logic [`SPI_DATA_W-1:0] spim;
    logic [`SPI_DATA_W-1:0] spcom;
    logic [`SPI_DATA_W-1:0] csmode [`SPI_NCS];
    logic                   don;
    tx_word_u               txbuf [`SPI_TXBUF_WORDS];
    logic [TXW-1:0]         tx_wptr;
    logic [15:0]            rxq [`SPI_RXQ_DEPTH];
    logic [RXW:0]           rx_wptr;
    logic [RXW:0]           rx_rptr;
    logic                   rx_full;
    logic                   rx_empty;
    logic                   wren;
    logic                   rden;
    logic                   tx_push;
    logic                   rx_pop;
    logic [`SPI_DATA_W-1:0] rd_mux;

    assign wren     = o_awready && i_awvalid && i_wvalid && (i_wstrb == 4'hF);
    assign rden     = o_arready && i_arvalid;
    assign tx_push  = wren && (i_awaddr == `SPI_ADDR_SPITF);
    assign rx_pop   = rden && (i_araddr == `SPI_ADDR_SPIRF) && !rx_empty;
    assign rx_empty = (rx_wptr == rx_rptr);
    assign rx_full  = (rx_wptr == {~rx_rptr[RXW], rx_rptr[RXW-1:0]});

    assign o_enable    = spmode[`SPI_SPMODE_EN];
    assign o_cs_idx    = spcom[`SPI_COM_CS_HI:`SPI_COM_CS_LO];
    assign o_tranlen   = spcom[`SPI_COM_LEN_HI:`SPI_COM_LEN_LO];
    assign o_csmode    = csmode[o_cs_idx];
    assign o_tx_word   = txbuf[i_tx_idx];
    assign o_interrupt = don & spim[`SPI_SPIE_DON];
    assign o_bresp     = 2'b00;
    assign o_rresp     = 2'b00;

    always_comb begin
        rd_mux = '0;
        case (i_araddr)
            `SPI_ADDR_SPMODE: rd_mux = spmode;
            `SPI_ADDR_SPIE:   rd_mux[`SPI_SPIE_DON] = don;
            `SPI_ADDR_SPIM:   rd_mux = spim;
            `SPI_ADDR_SPCOM:  rd_mux = spcom;
            `SPI_ADDR_SPIRF:  rd_mux[15:0] = rx_empty ? 16'h0000 : rxq[rx_rptr[RXW-1:0]];
            default: begin
                for (int i = 0; i < `SPI_NCS; i++) begin
                    if (i_araddr == `SPI_ADDR_CSMODE0 + `SPI_ADDR_W'(4 * i)) begin
                        rd_mux = csmode[i];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rdata   <= '0;
        end else begin
            // accept a write only with both channels valid and no response pending
            o_awready <= !o_awready && i_awvalid && i_wvalid && !o_bvalid;
            o_wready  <= !o_awready && i_awvalid && i_wvalid && !o_bvalid;
            if (o_awready && i_awvalid && i_wvalid) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            o_arready <= !o_arready && i_arvalid && !o_rvalid;
            if (rden) begin
                o_rvalid <= 1'b1;
                o_rdata  <= rd_mux;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode  <= '0;
            spim    <= '0;
            spcom   <= '0;
            don     <= 1'b0;
            o_start <= 1'b0;
            tx_wptr <= '0;
            rx_wptr <= '0;
            rx_rptr <= '0;
            for (int i = 0; i < `SPI_NCS; i++) begin
                csmode[i] <= '0;
            end
        end else begin
            o_start <= 1'b0;
            if (wren) begin
                case (i_awaddr)
                    `SPI_ADDR_SPMODE: spmode <= i_wdata;
                    `SPI_ADDR_SPIE: if (i_wdata[`SPI_SPIE_DON]) don <= 1'b0; // w1c
                    `SPI_ADDR_SPIM:   spim <= i_wdata;
                    `SPI_ADDR_SPCOM: if (!i_busy) begin
                        spcom   <= i_wdata;
                        o_start <= 1'b1;
                    end
                    default: begin
                        for (int i = 0; i < `SPI_NCS; i++) begin
                            if (i_awaddr == `SPI_ADDR_CSMODE0 + `SPI_ADDR_W'(4 * i)) begin
                                csmode[i] <= i_wdata;
                            end
                        end
                    end
                endcase
            end
            if (i_frame_done) begin
                don <= 1'b1;
            end
            if (o_start) begin
                tx_wptr <= '0;
            end else if (tx_push) begin
                tx_wptr <= tx_wptr + 1'b1;
            end
            if (i_rx_valid && !rx_full) begin
                rx_wptr <= rx_wptr + 1'b1; // overflow drops newest
            end
            if (rx_pop) begin
                rx_rptr <= rx_rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (tx_push) begin
            txbuf[tx_wptr] <= i_wdata;
        end
        if (i_rx_valid && !rx_full) begin
            rxq[rx_wptr[RXW-1:0]] <=
                (chars_per_word(o_csmode[`SPI_CSM_LEN_HI:`SPI_CSM_LEN_LO]) == 3'd4)
                ? {8'h00, i_rx_char[7:0]} : i_rx_char;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "spi_ctrl_settings.svh"

module spi_ctrl (
    input  wire                     S_SYSCLK,
    input  wire                     S_RESETN,
    input  wire  [`SPI_ADDR_W-1:0]  i_awaddr,
    input  wire                     i_awvalid,
    output wire                     o_awready,
    input  wire  [`SPI_DATA_W-1:0]  i_wdata,
    input  wire  [3:0]              i_wstrb,
    input  wire                     i_wvalid,
    output wire                     o_wready,
    output wire  [1:0]              o_bresp,
    output wire                     o_bvalid,
    input  wire                     i_bready,
    input  wire  [`SPI_ADDR_W-1:0]  i_araddr,
    input  wire                     i_arvalid,
    output wire                     o_arready,
    output wire  [`SPI_DATA_W-1:0]  o_rdata,
    output wire  [1:0]              o_rresp,
    output wire                     o_rvalid,
    input  wire                     i_rready,
    output wire                     o_interrupt,
    output wire                     o_spi_sck,
    output wire                     o_spi_mosi,
    input  wire                     i_spi_miso,
    output wire  [`SPI_NCS-1:0]     o_spi_sel
);

    import spi_reg_pkg::*;

    wire                                      enable;
    wire                                      start;
    wire [`SPI_COM_CS_HI-`SPI_COM_CS_LO:0]    cs_idx;
    wire [`SPI_COM_LEN_HI-`SPI_COM_LEN_LO:0]  tranlen;
    wire [`SPI_DATA_W-1:0]                    csmode;
    tx_word_u                                 tx_word;
    wire [$clog2(`SPI_TXBUF_WORDS)-1:0]       tx_idx;
    wire                                      rx_valid;
    wire [15:0]                               rx_char;
    wire                                      frame_done;
    wire                                      busy;
    wire                                      run;
    wire [7:0]                                divider;
    wire                                      sck;
    wire                                      lead;
    wire                                      trail;

    spi_axil_regs regs_inst (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_rx_valid(rx_valid), .i_rx_char(rx_char), .i_frame_done(frame_done),
        .i_busy(busy), .i_tx_idx(tx_idx), .o_enable(enable), .o_start(start),
        .o_cs_idx(cs_idx), .o_tranlen(tranlen), .o_csmode(csmode),
        .o_tx_word(tx_word), .o_interrupt(o_interrupt)
    );

    spi_frame_engine engine_inst (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_enable(enable), .i_start(start), .i_cs_idx(cs_idx), .i_tranlen(tranlen),
        .i_csmode(csmode), .i_tx_word(tx_word), .i_lead(lead), .i_trail(trail),
        .i_sck(sck), .i_spi_miso(i_spi_miso), .o_run(run), .o_divider(divider),
        .o_tx_idx(tx_idx), .o_spi_sck(o_spi_sck), .o_spi_mosi(o_spi_mosi),
        .o_spi_sel(o_spi_sel), .o_rx_valid(rx_valid), .o_rx_char(rx_char),
        .o_frame_done(frame_done), .o_busy(busy)
    );

    spi_baud_gen baud_inst (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_run(run), .i_cpol(csmode[`SPI_CSM_CPOL]), .i_divider(divider),
        .o_sck(sck), .o_lead(lead), .o_trail(trail)
    );

endmodule

`default_nettype wire

// ==== testbench/spi_ctrl_tb_bus.svh ====
`ifndef SPI_CTRL_TB_BUS_SVH
`define SPI_CTRL_TB_BUS_SVH

task automatic abort_run();
    fail_count++;
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
        $display("Fail %s, %s: expected 0x%08h actual 0x%08h", test_name, name, exp, act);
        abort_run();
    end
endtask

// full-word write, returns once the b response is seen
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge S_SYSCLK);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    @(posedge S_SYSCLK);
    while (!awready) @(posedge S_SYSCLK);
    check_value("wready with awready", 32'd1, {31'd0, wready});
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge S_SYSCLK);
    while (!bvalid) @(posedge S_SYSCLK); // bready held high
    check_value("bresp", 32'd0, {30'd0, bresp});
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(posedge S_SYSCLK);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge S_SYSCLK);
    while (!arready) @(posedge S_SYSCLK);
    arvalid <= 1'b0;
    @(posedge S_SYSCLK);
    while (!rvalid) @(posedge S_SYSCLK);
    data = rdata;
    check_value("rresp", 32'd0, {30'd0, rresp});
endtask

`endif

// ==== testbench/spi_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "spi_ctrl_settings.svh"

module spi_ctrl_tb;

    // frames take about 1.8k cycles, register traffic a few hundred more
    localparam int TIMEOUT_CYCLES = 20000;

    logic        S_SYSCLK;
    logic        S_RESETN;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
    wire         awready;
    wire         wready;
    wire  [1:0]  bresp;
    wire         bvalid;
    wire         arready;
    wire  [31:0] rdata;
    wire  [1:0]  rresp;
    wire         rvalid;
    wire         interrupt;
    wire         spi_sck;
    wire         spi_loop; // mosi fed straight back to miso
    wire  [3:0]  spi_sel;

    logic [31:0] words [4];
    logic [31:0] exp_q [$];
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] csm [4];
    string       test_name = "reset";
    int          cur_cs = 0;
    int          cycle_cnt = 0;
    int          fail_count = 0;
    logic        sck_prev = 1'b0;
    int          sck_toggles = 0; // sck edges seen with a select active
    int          sck_base;

    spi_ctrl spi_ctrl_inst (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
        .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
        .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
        .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
        .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
        .o_interrupt(interrupt), .o_spi_sck(spi_sck), .o_spi_mosi(spi_loop),
        .i_spi_miso(spi_loop), .o_spi_sel(spi_sel)
    );

    `include "spi_ctrl_tb_bus.svh"

    always #10 S_SYSCLK = ~S_SYSCLK;

    // char idx of a tx word, 8-bit slots up to length field 7, 16-bit above
    function automatic logic [15:0] exp_char(input logic [31:0] word, input int idx,
                                             input int len);
        logic [31:0] slot;
        logic [31:0] mask;
        slot = (len > 7) ? (word >> (16 * idx)) : (word >> (8 * idx));
        mask = (32'd1 << (len + 1)) - 32'd1;
        return 16'(slot & mask);
    endfunction

    function automatic logic [31:0] mode_word(input logic cpol, input logic cpha,
                                              input logic rev, input int len, input int pm,
                                              input int bef, input int aft);
        logic [31:0] m;
        m = '0;
        m[`SPI_CSM_CPOL] = cpol;
        m[`SPI_CSM_CPHA] = cpha;
        m[`SPI_CSM_REV]  = rev;
        m[`SPI_CSM_LEN_HI:`SPI_CSM_LEN_LO] = 4'(len);
        m[`SPI_CSM_PM_HI:`SPI_CSM_PM_LO]   = 4'(pm);
        m[`SPI_CSM_BEF_HI:`SPI_CSM_BEF_LO] = 4'(bef);
        m[`SPI_CSM_AFT_HI:`SPI_CSM_AFT_LO] = 4'(aft);
        return m;
    endfunction

    task automatic wait_frame_done();
        logic [31:0] sts;
        sts = '0;
        while (!sts[`SPI_SPIE_DON]) read_reg(`SPI_ADDR_SPIE, sts);
    endtask

    // push tx words and queue what the loopback must bring back
    task automatic load_frame(input int nwords, input int nchars, input int len);
        int cpw;
        cpw = (len > 7) ? 2 : 4;
        for (int i = 0; i < nwords; i++) begin
            words[i] = $urandom;
            write_reg(`SPI_ADDR_SPITF, words[i]);
        end
        for (int k = 0; k < nchars; k++) begin
            exp_q.push_back({16'h0000, exp_char(words[k / cpw], k % cpw, len)});
        end
    endtask

    task automatic start_frame(input int cs, input int tranlen);
        logic [31:0] com;
        com = '0;
        com[`SPI_COM_CS_HI:`SPI_COM_CS_LO]   = 2'(cs);
        com[`SPI_COM_LEN_HI:`SPI_COM_LEN_LO] = 16'(tranlen);
        cur_cs = cs;
        write_reg(`SPI_ADDR_SPCOM, com);
    endtask

    task automatic drain_rx(input int n);
        for (int i = 0; i < n; i++) begin
            read_reg(`SPI_ADDR_SPIRF, rd);
        end
        @(posedge S_SYSCLK); // let the compare process take the last one
        check_value("chars left unread", 32'd0, 32'(exp_q.size()));
    endtask

    // compares every SPIRF read against the reference queue
    always @(posedge S_SYSCLK) begin
        if (rvalid && rready && araddr == `SPI_ADDR_SPIRF) begin
            if (exp_q.size() == 0) begin
                $display("SPIRF returned a character when none was expected");
                abort_run();
            end else begin
                check_value("SPIRF char", exp_q.pop_front(), rdata);
            end
        end
    end

    always @(posedge S_SYSCLK) begin
        if (S_RESETN && spi_sel != 4'hF) begin
            check_value("active select", {28'd0, ~(4'b0001 << cur_cs)}, {28'd0, spi_sel});
        end
    end

    // two sck edges per bit, no others while selected
    always @(posedge S_SYSCLK) begin
        sck_prev <= spi_sck;
        if (S_RESETN && spi_sel != 4'hF && spi_sck != sck_prev) begin
            sck_toggles <= sck_toggles + 1;
        end
    end

    always @(posedge S_SYSCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s, DUT stopped responding",
                     cycle_cnt, test_name);
            abort_run();
        end
    end

    initial begin
        S_SYSCLK = 1'b0;
        S_RESETN = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        rd       = $urandom(32'h96667795);
        repeat (8) @(posedge S_SYSCLK);
        S_RESETN <= 1'b1;
        @(posedge S_SYSCLK);
        check_value("selects idle", 32'hF, {28'd0, spi_sel});
        check_value("sck idle", 32'd0, {31'd0, spi_sck});
        check_value("interrupt", 32'd0, {31'd0, interrupt});
        check_value("bus handshakes idle", 32'd0,
                    {27'd0, awready, wready, bvalid, arready, rvalid});

        test_name = "register readback";
        val = $urandom;
        write_reg(`SPI_ADDR_SPIM, val);
        read_reg(`SPI_ADDR_SPIM, rd);
        check_value("SPIM", val, rd);
        for (int i = 0; i < 4; i++) begin
            csm[i] = $urandom;
            write_reg(`SPI_ADDR_CSMODE0 + 8'(4 * i), csm[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_reg(`SPI_ADDR_CSMODE0 + 8'(4 * i), rd);
            check_value("CS mode", csm[i], rd);
        end
        write_reg(`SPI_ADDR_SPIM, 32'd0);

        test_name = "loopback 8-bit";
        write_reg(`SPI_ADDR_SPMODE, 32'd1 << `SPI_SPMODE_EN);
        write_reg(`SPI_ADDR_CSMODE0, mode_word(1'b0, 1'b0, 1'b0, 7, 1, 1, 1));
        load_frame(4, 16, 7);
        sck_base = sck_toggles;
        start_frame(0, 15);
        wait_frame_done();
        check_value("selects after frame", 32'hF, {28'd0, spi_sel});
        check_value("sck edges", 32'(2 * 8 * 16), 32'(sck_toggles - sck_base));
        write_reg(`SPI_ADDR_SPIE, 32'd1);
        drain_rx(16);

        test_name = "loopback 16-bit rev cpol cpha cs2";
        write_reg(`SPI_ADDR_CSMODE0 + 8'd8, mode_word(1'b1, 1'b1, 1'b1, 15, 1, 2, 2));
        load_frame(2, 4, 15);
        sck_base = sck_toggles;
        start_frame(2, 3);
        while (spi_sel[2]) @(posedge S_SYSCLK);
        check_value("select during frame", 32'hB, {28'd0, spi_sel});
        check_value("sck before shift", 32'd1, {31'd0, spi_sck});
        wait_frame_done();
        check_value("sck after frame", 32'd1, {31'd0, spi_sck});
        check_value("selects after frame", 32'hF, {28'd0, spi_sel});
        check_value("sck edges", 32'(2 * 16 * 4), 32'(sck_toggles - sck_base));
        write_reg(`SPI_ADDR_SPIE, 32'd1);
        drain_rx(4);

        test_name = "interrupt";
        write_reg(`SPI_ADDR_SPIM, 32'd1);
        check_value("irq with DON clear", 32'd0, {31'd0, interrupt});
        write_reg(`SPI_ADDR_CSMODE0 + 8'd4, mode_word(1'b0, 1'b0, 1'b0, 7, 0, 0, 0));
        load_frame(1, 1, 7);
        start_frame(1, 0);
        while (!interrupt) @(posedge S_SYSCLK);
        read_reg(`SPI_ADDR_SPIE, rd);
        check_value("SPIE DON", 32'd1, rd);
        drain_rx(1);
        write_reg(`SPI_ADDR_SPIE, 32'd1);
        check_value("irq after DON clear", 32'd0, {31'd0, interrupt});
        write_reg(`SPI_ADDR_SPIM, 32'd0);
        load_frame(1, 1, 7);
        start_frame(1, 0);
        wait_frame_done();
        check_value("irq masked", 32'd0, {31'd0, interrupt});
        write_reg(`SPI_ADDR_SPIE, 32'd1);
        drain_rx(1);

        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_ctrl.f ====
+incdir+hw
+incdir+testbench
hw/spi_reg_pkg.sv
hw/spi_link_pkg.sv
hw/spi_baud_gen.sv
hw/spi_frame_engine.sv
hw/spi_axil_regs.sv
hw/spi_ctrl.sv
testbench/spi_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spi_ctrl testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module spi_ctrl_tb -f spi_ctrl.f -o spi_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/spi_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
